// ==== design/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int LINES = cache_pkg::LINES
) (
  input  logic                                 clk,
  input  logic                                 reset,

  input  logic                                 cpu_req_valid,
  output logic                                 cpu_req_ready,
  input  logic [cache_pkg::WORD_ADDR_BITS-1:0] cpu_req_addr,
  input  logic [cache_pkg::CPU_WIDTH-1:0]      cpu_req_data,
  input  logic [cache_pkg::CPU_WIDTH/8-1:0]    cpu_req_write,   // All-zero byte mask is a read

  output logic                                 cpu_resp_valid,
  output logic [cache_pkg::CPU_WIDTH-1:0]      cpu_resp_data,

  output logic                                 mem_req_valid,
  input  logic                                 mem_req_ready,
  output logic [cache_pkg::MEM_ADDR_BITS-1:0]  mem_req_addr,
  output logic                                 mem_req_rw,

  output logic                                 mem_req_data_valid,
  input  logic                                 mem_req_data_ready,
  output logic [cache_pkg::MEM_WIDTH-1:0]      mem_req_data_bits,

  input  logic                                 mem_resp_valid,
  input  logic [cache_pkg::MEM_WIDTH-1:0]      mem_resp_data,

  sram_if.ctrl                                 meta,
  sram_if.ctrl                                 bank0,
  sram_if.ctrl                                 bank1,
  sram_if.ctrl                                 bank2,
  sram_if.ctrl                                 bank3
);

  import cache_pkg::*;

  localparam int WORDS    = MEM_WIDTH / CPU_WIDTH;   // One bank per word of a beat
  localparam int INDEX_LO = BEAT_BITS + WORD_BITS;
  localparam int TAG_LO   = INDEX_LO + INDEX_BITS;

  // ------------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------------
  cache_state_t          state;
  logic [BEAT_BITS-1:0]  beat_cnt;   // Shared by write-back and fetch
  logic                  clearing;   // Metadata sweep after reset
  logic [INDEX_BITS-1:0] clr_idx;
  logic                  reread;     // LOOKUP must wait for fresh SRAM data

  // Held request and victim
  logic [WORD_ADDR_BITS-1:0] hold_addr;
  logic [CPU_WIDTH-1:0]      hold_data;
  logic [CPU_WIDTH/8-1:0]    hold_write;
  logic [TAG_BITS-1:0]       victim_tag;

  logic [TAG_BITS-1:0]   hold_tag;
  logic [INDEX_BITS-1:0] hold_index;
  logic [BEAT_BITS-1:0]  hold_beat;
  logic [WORD_BITS-1:0]  hold_word;
  logic [INDEX_BITS-1:0] in_index;
  logic [BEAT_BITS-1:0]  in_beat;

  assign hold_tag   = hold_addr[TAG_LO +: TAG_BITS];
  assign hold_index = hold_addr[INDEX_LO +: INDEX_BITS];
  assign hold_beat  = hold_addr[WORD_BITS +: BEAT_BITS];
  assign hold_word  = hold_addr[0 +: WORD_BITS];
  assign in_index   = cpu_req_addr[INDEX_LO +: INDEX_BITS];
  assign in_beat    = cpu_req_addr[WORD_BITS +: BEAT_BITS];

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------
  meta_entry_t          meta_q;
  logic                 cpu_accept;
  logic                 hit;
  logic                 victim_dirty;
  logic                 lookup_done;
  logic                 read_hit;
  logic                 wb_accept;
  logic                 fetch_beat;
  logic                 last_beat;

  assign meta_q       = meta.dout;
  assign cpu_accept   = cpu_req_valid && cpu_req_ready;
  assign hit          = meta_q.valid && (meta_q.tag == hold_tag);
  assign victim_dirty = meta_q.valid && meta_q.dirty;
  assign lookup_done  = (state == LOOKUP) && !reread;
  assign read_hit     = lookup_done && hit && (hold_write == '0);
  assign wb_accept    = mem_req_ready && mem_req_data_ready;   // Address and data go together
  assign fetch_beat   = (state == FETCH) && mem_resp_valid;
  assign last_beat    = (beat_cnt == BEAT_BITS'(BEATS - 1));

  // No new request in the response cycle
  assign cpu_req_ready = (state == IDLE) && !clearing && !cpu_resp_valid;

  // ------------------------------------------------------------------
  // Metadata store
  // ------------------------------------------------------------------
  // Sweep address first, then the incoming index, then the held one
  always_comb begin
    if (clearing) begin
      meta.addr = clr_idx;
    end else if (state == IDLE) begin
      meta.addr = in_index;
    end else begin
      meta.addr = hold_index;
    end
  end

  assign meta.we    = clearing || (state == WRITE) || (fetch_beat && last_beat);
  assign meta.wmask = '1;
  assign meta.din   = '{tag:   clearing ? '0 : hold_tag,
                        valid: !clearing,
                        dirty: (state == WRITE)};   // Fill installs a clean line

  // ------------------------------------------------------------------
  // Data banks
  // ------------------------------------------------------------------
  logic [INDEX_BITS+BEAT_BITS-1:0] bank_addr;
  logic [CPU_WIDTH/8-1:0]          bank_mask;
  logic [WORDS-1:0]                bank_we;
  logic [CPU_WIDTH-1:0]            bank_din  [WORDS];
  logic [CPU_WIDTH-1:0]            bank_dout [WORDS];

  always_comb begin
    case (state)
      IDLE:               bank_addr = {in_index, in_beat};
      WB_WAIT, WB, FETCH: bank_addr = {hold_index, beat_cnt};
      default:            bank_addr = {hold_index, hold_beat};
    endcase
  end

  assign bank_mask = (state == FETCH) ? '1 : hold_write;

  always_comb begin
    for (int i = 0; i < WORDS; i++) begin
      bank_we[i]  = fetch_beat || ((state == WRITE) && (hold_word == WORD_BITS'(i)));
      bank_din[i] = (state == FETCH) ? mem_resp_data[i*CPU_WIDTH +: CPU_WIDTH] : hold_data;
    end
  end

  assign bank0.we    = bank_we[0];
  assign bank0.wmask = bank_mask;
  assign bank0.addr  = bank_addr;
  assign bank0.din   = bank_din[0];
  assign bank_dout[0] = bank0.dout;

  assign bank1.we    = bank_we[1];
  assign bank1.wmask = bank_mask;
  assign bank1.addr  = bank_addr;
  assign bank1.din   = bank_din[1];
  assign bank_dout[1] = bank1.dout;

  assign bank2.we    = bank_we[2];
  assign bank2.wmask = bank_mask;
  assign bank2.addr  = bank_addr;
  assign bank2.din   = bank_din[2];
  assign bank_dout[2] = bank2.dout;

  assign bank3.we    = bank_we[3];
  assign bank3.wmask = bank_mask;
  assign bank3.addr  = bank_addr;
  assign bank3.din   = bank_din[3];
  assign bank_dout[3] = bank3.dout;

  // ------------------------------------------------------------------
  // External memory port
  // ------------------------------------------------------------------
  assign mem_req_valid      = (state == WB) || (state == FETCH_WAIT);
  assign mem_req_rw         = (state == WB);
  assign mem_req_data_valid = (state == WB);

  // Write-back goes to the victim tag and fetch to the held tag
  assign mem_req_addr = {(state == WB) ? victim_tag : hold_tag, hold_index, beat_cnt};

  assign mem_req_data_bits = {bank_dout[3], bank_dout[2], bank_dout[1], bank_dout[0]};

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= IDLE;
      beat_cnt       <= '0;
      clearing       <= 1'b1;
      clr_idx        <= '0;
      reread         <= 1'b0;
      cpu_resp_valid <= 1'b0;
    end else begin
      cpu_resp_valid <= 1'b0;

      if (clearing) begin
        clr_idx <= clr_idx + 1'b1;
        if (clr_idx == INDEX_BITS'(LINES - 1)) begin
          clearing <= 1'b0;
        end
      end

      case (state)
        IDLE: begin
          if (cpu_accept) state <= LOOKUP;
        end
        LOOKUP: begin
          if (reread) begin
            reread <= 1'b0;   // Fill just landed so read again
          end else if (hit) begin
            if (hold_write == '0) begin
              cpu_resp_valid <= 1'b1;
              state          <= IDLE;
            end else begin
              state <= WRITE;
            end
          end else if (victim_dirty) begin
            state <= WB_WAIT;
          end else begin
            state <= FETCH_WAIT;
          end
        end
        WRITE: state <= IDLE;
        WB_WAIT: state <= WB;   // Bank read of the next beat
        WB: begin
          if (wb_accept) begin
            beat_cnt <= beat_cnt + 1'b1;
            state    <= last_beat ? FETCH_WAIT : WB_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (mem_req_ready) state <= FETCH;
        end
        FETCH: begin
          if (mem_resp_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              reread <= 1'b1;
              state  <= LOOKUP;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request payload, victim tag and read data
  always_ff @(posedge clk) begin
    if (cpu_accept) begin
      hold_addr  <= cpu_req_addr;
      hold_data  <= cpu_req_data;
      hold_write <= cpu_req_write;
    end
    if (lookup_done) begin
      victim_tag <= meta_q.tag;
    end
    if (read_hit) begin
      cpu_resp_data <= bank_dout[hold_word];   // Bank picked by word number
    end
  end

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

  // ------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------
  localparam int LINES          = 64;   // Direct-mapped lines
  localparam int WORD_ADDR_BITS = 30;   // Processor word address
  localparam int TAG_BITS       = 20;
  localparam int INDEX_BITS     = 6;
  localparam int BEAT_BITS      = 2;    // Beat within a line
  localparam int WORD_BITS      = 2;    // Word within a beat
  localparam int CPU_WIDTH      = 32;
  localparam int MEM_WIDTH      = 128;
  localparam int BEATS          = 4;    // 128-bit beats per 64-byte line

  // Beat address seen by external memory
  localparam int MEM_ADDR_BITS  = WORD_ADDR_BITS - WORD_BITS;

  // ------------------------------------------------------------------
  // Metadata store entry, one per line
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic                valid;
    logic                dirty;   // Line differs from memory
  } meta_entry_t;

  // ------------------------------------------------------------------
  // Controller states
  // ------------------------------------------------------------------
  // Memory-side states share the top bit
  typedef enum logic [2:0] {
    IDLE       = 3'b000,
    LOOKUP     = 3'b001,
    WRITE      = 3'b010,
    FETCH_WAIT = 3'b100,
    FETCH      = 3'b101,
    WB_WAIT    = 3'b110,
    WB         = 3'b111
  } cache_state_t;

endpackage

// ==== design/cache_top.sv ====
`timescale 1ns/10ps

module cache_top #(
  parameter int LINES = cache_pkg::LINES
) (
  input  logic                                 clk,
  input  logic                                 reset,

  input  logic                                 cpu_req_valid,
  output logic                                 cpu_req_ready,
  input  logic [cache_pkg::WORD_ADDR_BITS-1:0] cpu_req_addr,
  input  logic [cache_pkg::CPU_WIDTH-1:0]      cpu_req_data,
  input  logic [cache_pkg::CPU_WIDTH/8-1:0]    cpu_req_write,

  output logic                                 cpu_resp_valid,
  output logic [cache_pkg::CPU_WIDTH-1:0]      cpu_resp_data,

  output logic                                 mem_req_valid,
  input  logic                                 mem_req_ready,
  output logic [cache_pkg::MEM_ADDR_BITS-1:0]  mem_req_addr,
  output logic                                 mem_req_rw,

  output logic                                 mem_req_data_valid,
  input  logic                                 mem_req_data_ready,
  output logic [cache_pkg::MEM_WIDTH-1:0]      mem_req_data_bits,

  input  logic                                 mem_resp_valid,
  input  logic [cache_pkg::MEM_WIDTH-1:0]      mem_resp_data
);

  import cache_pkg::*;

  localparam int WORDS = MEM_WIDTH / CPU_WIDTH;

  // ------------------------------------------------------------------
  // SRAM buses
  // ------------------------------------------------------------------
  sram_if #(.T(meta_entry_t), .DEPTH(LINES)) meta_bus ();

  // One bank per word of a beat, addressed by {index, beat}
  sram_if #(.T(logic [CPU_WIDTH-1:0]), .DEPTH(LINES * BEATS)) bank_bus [WORDS] ();

  cache_ctrl #(.LINES(LINES)) i_ctrl (
    .clk                (clk),
    .reset              (reset),
    .cpu_req_valid      (cpu_req_valid),
    .cpu_req_ready      (cpu_req_ready),
    .cpu_req_addr       (cpu_req_addr),
    .cpu_req_data       (cpu_req_data),
    .cpu_req_write      (cpu_req_write),
    .cpu_resp_valid     (cpu_resp_valid),
    .cpu_resp_data      (cpu_resp_data),
    .mem_req_valid      (mem_req_valid),
    .mem_req_ready      (mem_req_ready),
    .mem_req_addr       (mem_req_addr),
    .mem_req_rw         (mem_req_rw),
    .mem_req_data_valid (mem_req_data_valid),
    .mem_req_data_ready (mem_req_data_ready),
    .mem_req_data_bits  (mem_req_data_bits),
    .mem_resp_valid     (mem_resp_valid),
    .mem_resp_data      (mem_resp_data),
    .meta               (meta_bus),
    .bank0              (bank_bus[0]),
    .bank1              (bank_bus[1]),
    .bank2              (bank_bus[2]),
    .bank3              (bank_bus[3])
  );

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------
  sram_1rw #(.T(meta_entry_t), .DEPTH(LINES)) i_meta (
    .clk (clk),
    .bus (meta_bus)
  );

  for (genvar i = 0; i < WORDS; i++) begin : g_bank
    sram_1rw #(.T(logic [CPU_WIDTH-1:0]), .DEPTH(LINES * BEATS)) i_bank (
      .clk (clk),
      .bus (bank_bus[i])
    );
  end

endmodule

// ==== design/sram_1rw.sv ====
`timescale 1ns/10ps

module sram_1rw #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 256
) (
  input logic clk,
  sram_if.mem bus
);

  localparam int W = $bits(T);

  logic [W-1:0] mem [DEPTH];
  logic [W-1:0] din_bits;
  logic [W-1:0] bit_mask;

  assign din_bits = bus.din;

  // Spread the byte mask over the payload bits
  always_comb begin
    for (int b = 0; b < W; b++) begin
      bit_mask[b] = bus.wmask[b / 8];
    end
  end

  // Read returns the word as it was before this edge
  always_ff @(posedge clk) begin
    if (bus.we) begin
      mem[bus.addr] <= (mem[bus.addr] & ~bit_mask) | (din_bits & bit_mask);
    end
    bus.dout <= T'(mem[bus.addr]);
  end

endmodule

// ==== design/sram_if.sv ====
`timescale 1ns/10ps

// Port bundle of one single-port memory
interface sram_if #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 256
);

  localparam int AW = $clog2(DEPTH);
  localparam int MW = ($bits(T) + 7) / 8;   // One mask bit per byte, last byte may be partial

  logic          we;
  logic [MW-1:0] wmask;
  logic [AW-1:0] addr;
  T              din;
  T              dout;   // Valid the cycle after addr

  // Controller side
  modport ctrl (output we, wmask, addr, din, input dout);

  // Storage side
  modport mem (input we, wmask, addr, din, output dout);

endinterface

// ==== dv/cache_asserts.sv ====
`timescale 1ns/10ps

module cache_asserts (
  input logic                                clk,
  input logic                                reset,
  input logic                                cpu_req_valid,
  input logic                                cpu_req_ready,
  input logic [cache_pkg::CPU_WIDTH/8-1:0]   cpu_req_write,
  input logic                                cpu_resp_valid,
  input logic                                mem_req_valid,
  input logic                                mem_req_ready,
  input logic [cache_pkg::MEM_ADDR_BITS-1:0] mem_req_addr,
  input logic                                mem_req_rw,
  input logic                                mem_req_data_valid,
  input logic                                mem_req_data_ready,
  input logic                                hit,
  input cache_pkg::cache_state_t             state
);

  import cache_pkg::*;

  int assert_errors = 0;   // Failed assertions

  // Response never while a new request can be taken
  a_resp_not_ready: assert property (@(posedge clk) disable iff (reset)
    !(cpu_resp_valid && cpu_req_ready))
    else begin
      assert_errors++;
      $error("cpu_resp_valid high while cpu_req_ready is high");
    end

  // Request held with a stable address until taken
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !(mem_req_ready && (!mem_req_rw || mem_req_data_ready))
      |=> mem_req_valid && $stable(mem_req_addr))
    else begin
      assert_errors++;
      $error("mem_req_valid or mem_req_addr changed before acceptance");
    end

  a_read_hit_latency: assert property (@(posedge clk) disable iff (reset)
    $past(cpu_req_valid && cpu_req_ready && (cpu_req_write == '0)) && hit
      |=> cpu_resp_valid)
    else begin
      assert_errors++;
      $error("Read hit response not two cycles after acceptance");
    end

  a_quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> (state == IDLE) && !cpu_resp_valid && !mem_req_valid &&
                     !mem_req_data_valid && !cpu_req_ready)
    else begin
      assert_errors++;
      $error("Controller not idle and quiet in the first cycle after reset");
    end

endmodule

bind cache_ctrl cache_asserts i_asserts (
  .clk                (clk),
  .reset              (reset),
  .cpu_req_valid      (cpu_req_valid),
  .cpu_req_ready      (cpu_req_ready),
  .cpu_req_write      (cpu_req_write),
  .cpu_resp_valid     (cpu_resp_valid),
  .mem_req_valid      (mem_req_valid),
  .mem_req_ready      (mem_req_ready),
  .mem_req_addr       (mem_req_addr),
  .mem_req_rw         (mem_req_rw),
  .mem_req_data_valid (mem_req_data_valid),
  .mem_req_data_ready (mem_req_data_ready),
  .hit                (hit),
  .state              (state)
);

// ==== dv/mem_model.sv ====
`timescale 1ns/10ps

// External memory, one outstanding line read, random back-pressure
module mem_model (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                mem_req_valid,
  output logic                                mem_req_ready,
  input  logic [cache_pkg::MEM_ADDR_BITS-1:0] mem_req_addr,
  input  logic                                mem_req_rw,
  input  logic                                mem_req_data_valid,
  output logic                                mem_req_data_ready,
  input  logic [cache_pkg::MEM_WIDTH-1:0]     mem_req_data_bits,
  output logic                                mem_resp_valid,
  output logic [cache_pkg::MEM_WIDTH-1:0]     mem_resp_data
);

  import cache_pkg::*;

  logic [MEM_WIDTH-1:0]     store [logic [MEM_ADDR_BITS-1:0]];   // Written beats only
  logic [31:0]              lfsr;
  logic                     rd_pending;
  logic [MEM_ADDR_BITS-1:0] rd_addr;
  logic [BEAT_BITS-1:0]     rd_cnt;     // Next beat to return

  // Untouched words read back as their own word address
  function automatic logic [MEM_WIDTH-1:0] read_beat(input logic [MEM_ADDR_BITS-1:0] a);
    logic [MEM_WIDTH-1:0] b;
    if (store.exists(a)) begin
      return store[a];
    end
    for (int w = 0; w < MEM_WIDTH / CPU_WIDTH; w++) begin
      b[w*CPU_WIDTH +: CPU_WIDTH] = CPU_WIDTH'({a, WORD_BITS'(w)});
    end
    return b;
  endfunction

  // Galois LFSR, one step per bit
  function logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  // ------------------------------------------------------------------
  // Outputs change on the falling edge
  // ------------------------------------------------------------------
  initial begin
    lfsr               = 32'h5fe0_5c09;
    mem_req_ready      = 1'b0;
    mem_req_data_ready = 1'b0;
    mem_resp_valid     = 1'b0;
    mem_resp_data      = '0;
    forever begin
      @(negedge clk);
      if (reset) begin
        mem_req_ready      = 1'b0;
        mem_req_data_ready = 1'b0;
        mem_resp_valid     = 1'b0;
      end else begin
        mem_req_ready      = take_bit();
        mem_req_data_ready = take_bit();
        if (rd_pending) begin
          mem_resp_valid = take_bit();   // Random gaps between beats
        end else begin
          mem_resp_valid = 1'b0;
        end
        mem_resp_data = read_beat({rd_addr[MEM_ADDR_BITS-1:BEAT_BITS], rd_cnt});
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
      rd_cnt     <= '0;
    end else begin
      if (mem_req_valid && mem_req_ready && mem_req_rw &&
          mem_req_data_valid && mem_req_data_ready) begin
        store[mem_req_addr] = mem_req_data_bits;
      end
      if (mem_req_valid && mem_req_ready && !mem_req_rw) begin
        rd_pending <= 1'b1;
        rd_addr    <= mem_req_addr;
        rd_cnt     <= '0;
      end
      if (mem_resp_valid) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == BEAT_BITS'(BEATS - 1)) rd_pending <= 1'b0;
      end
    end
  end

endmodule

// ==== dv/tb_cache.sv ====
`timescale 1ns/10ps

module tb_cache;

  import cache_pkg::*;

  localparam int N_DIRECTED = 17;
  localparam int N_RANDOM   = 300;
  localparam int N_OPS      = N_DIRECTED + N_RANDOM;
  localparam int MAX_CYCLES = N_OPS * 400;   // Write-back plus fetch under heavy stalls

  logic                      clk;
  logic                      reset;
  logic                      cpu_req_valid;
  logic                      cpu_req_ready;
  logic [WORD_ADDR_BITS-1:0] cpu_req_addr;
  logic [CPU_WIDTH-1:0]      cpu_req_data;
  logic [CPU_WIDTH/8-1:0]    cpu_req_write;
  logic                      cpu_resp_valid;
  logic [CPU_WIDTH-1:0]      cpu_resp_data;
  logic                      mem_req_valid;
  logic                      mem_req_ready;
  logic [MEM_ADDR_BITS-1:0]  mem_req_addr;
  logic                      mem_req_rw;
  logic                      mem_req_data_valid;
  logic                      mem_req_data_ready;
  logic [MEM_WIDTH-1:0]      mem_req_data_bits;
  logic                      mem_resp_valid;
  logic [MEM_WIDTH-1:0]      mem_resp_data;

  logic [CPU_WIDTH-1:0] shadow [logic [WORD_ADDR_BITS-1:0]];
  logic [CPU_WIDTH-1:0] expected [$];   // Reads still waiting for a response
  logic [31:0]          lfsr;
  int                   data_errors;
  int                   other_errors;
  int                   cycles;

  always #10 clk = ~clk;

  cache_top #(.LINES(LINES)) i_dut (.*);

  mem_model i_mem (.*);

  // ------------------------------------------------------------------
  // Reference and helpers
  // ------------------------------------------------------------------
  // Byte merge into the shadow memory, returns the word after the op
  function automatic logic [CPU_WIDTH-1:0] model_op(input logic [WORD_ADDR_BITS-1:0] a,
                                                    input logic [CPU_WIDTH-1:0] d,
                                                    input logic [CPU_WIDTH/8-1:0] m);
    logic [CPU_WIDTH-1:0] w;
    w = shadow.exists(a) ? shadow[a] : CPU_WIDTH'(a);
    for (int b = 0; b < CPU_WIDTH / 8; b++) begin
      if (m[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    if (m != '0) shadow[a] = w;
    return w;
  endfunction

  function automatic logic [WORD_ADDR_BITS-1:0] make_addr(input logic [TAG_BITS-1:0] tag,
                                                          input logic [INDEX_BITS-1:0] idx,
                                                          input logic [BEAT_BITS-1:0] beat,
                                                          input logic [WORD_BITS-1:0] word);
    return {tag, idx, beat, word};
  endfunction

  // Galois LFSR, stepped once per bit taken
  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic issue(input logic [WORD_ADDR_BITS-1:0] a, input logic [CPU_WIDTH-1:0] d,
                       input logic [CPU_WIDTH/8-1:0] m);
    logic [CPU_WIDTH-1:0] exp;
    cpu_req_valid = 1'b1;
    cpu_req_addr  = a;
    cpu_req_data  = d;
    cpu_req_write = m;
    while (!cpu_req_ready) @(negedge clk);
    exp = model_op(a, d, m);
    if (m == '0) expected.push_back(exp);
    @(negedge clk);
    cpu_req_valid = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Response compare and timeout
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (!reset && cpu_resp_valid) begin
      if (expected.size() == 0) begin
        other_errors++;
        $display("Read response arrived with no read outstanding");
      end else begin
        check_value("cpu_resp_data", cpu_resp_data, expected.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the cache stopped making progress", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    logic [WORD_ADDR_BITS-1:0] a;
    logic [WORD_ADDR_BITS-1:0] c;
    logic [1:0]                tag_sel;
    logic [1:0]                idx_sel;
    logic [CPU_WIDTH/8-1:0]    m;
    int                        total;
    clk           = 1'b0;
    reset         = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req_addr  = '0;
    cpu_req_data  = '0;
    cpu_req_write = '0;
    lfsr          = 32'h5fe0_5c09;
    data_errors   = 0;
    other_errors  = 0;
    cycles        = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Clean misses, then hits on the same words
    for (int i = 0; i < 4; i++) begin
      a = make_addr(20'h00010, 6'(i), 2'(i), 2'(3 - i));
      issue(a, '0, '0);
      issue(a, '0, '0);
    end

    // Byte merges into a resident line
    issue(make_addr(20'h00010, 6'd0, 2'd0, 2'd3), 32'ha5a5_5a5a, 4'b0101);
    issue(make_addr(20'h00010, 6'd0, 2'd2, 2'd1), 32'h1234_5678, 4'b1000);
    issue(make_addr(20'h00010, 6'd0, 2'd0, 2'd3), '0, '0);
    issue(make_addr(20'h00010, 6'd0, 2'd2, 2'd1), '0, '0);

    // Write miss allocates, then merges
    issue(make_addr(20'h00020, 6'd9, 2'd1, 2'd2), 32'hdead_beef, 4'b0110);
    issue(make_addr(20'h00020, 6'd9, 2'd1, 2'd2), '0, '0);

    // Dirty victim written back, then fetched again
    c = make_addr(20'h00030, 6'd17, 2'd3, 2'd0);
    issue(c, 32'hcafe_f00d, 4'b1111);
    issue(make_addr(20'h00031, 6'd17, 2'd3, 2'd0), '0, '0);
    issue(c, '0, '0);

    // Random mix over four tags and four indices
    for (int n = 0; n < N_RANDOM; n++) begin
      tag_sel = 2'(rand_bits(2));
      idx_sel = 2'(rand_bits(2));
      a = make_addr(20'h00100 + 20'(tag_sel), 6'd40 + 6'(idx_sel),
                    2'(rand_bits(2)), 2'(rand_bits(2)));
      m = rand_bits(1) ? 4'(rand_bits(4)) : 4'b0000;
      issue(a, rand_bits(32), m);
    end

    while (expected.size() != 0 || !cpu_req_ready) @(negedge clk);
    repeat (2) @(negedge clk);

    total = data_errors + other_errors + i_dut.i_ctrl.i_asserts.assert_errors;
    $display("Errors: %0d mismatch, %0d other, %0d assertion", data_errors, other_errors,
             i_dut.i_ctrl.i_asserts.assert_errors);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/cache_pkg.sv
design/sram_if.sv
design/sram_1rw.sv
design/cache_ctrl.sv
design/cache_top.sv
dv/mem_model.sv
dv/cache_asserts.sv
dv/tb_cache.sv
